// ==== cache_defs.svh ====
/*
  Geometry of the two-way data cache. Covers the byte address split into tag,
  set index and line offset, plus the word and line widths and the set count
*/
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Byte address width seen by the requester
`define ADDR_BITS 16

// Address split, offset at the bottom, then index, then tag at the top
`define OFFSET_BITS 4
`define INDEX_BITS 4
`define TAG_BITS (`ADDR_BITS - `INDEX_BITS - `OFFSET_BITS)

// A line is four 32-bit words, so address bits 3:2 select the word
`define WORD_BITS 32
`define LINE_WORDS 4
`define LINE_BITS (`WORD_BITS * `LINE_WORDS)

// One set per index value
`define NUM_SETS (1 << `INDEX_BITS)

`endif

// ==== cache_pkg.sv ====
/*
  Cache types. Width typedefs for addresses, tags, words and lines, and the
  operation code carried by the request strobe
*/
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

  // Address and its fields
  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef logic [`INDEX_BITS-1:0] index_t;
  typedef logic [`TAG_BITS-1:0] tag_t;

  // Payload
  typedef logic [`WORD_BITS-1:0] word_t;
  typedef logic [`LINE_BITS-1:0] line_t;

  // One enable bit per word of a line
  typedef logic [`LINE_WORDS-1:0] wordMask_t;

  // Requester operations, one per strobe
  typedef enum logic [1:0] {
    OpRead       = 2'd0,
    OpWrite      = 2'd1,
    OpFill       = 2'd2,
    OpInvalidate = 2'd3
  } cacheOp_t;

endpackage

`default_nettype wire

// ==== sram2p.sv ====
/*
  Simple dual-port synchronous RAM. One write port and one registered read
  port. A read of the address being written returns the old contents
*/
`default_nettype none

module sram2p #(
  parameter int Width = 32,
  parameter int Depth = 16
) (
  input  wire logic                     clk,
  input  wire logic [$clog2(Depth)-1:0] readAddr,
  output logic      [Width-1:0]         readData,
  input  wire logic [$clog2(Depth)-1:0] writeAddr,
  input  wire logic                     writeEnable,
  input  wire logic [Width-1:0]         writeData
);

  logic [Width-1:0] mem [Depth];

  // Write port
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      mem[writeAddr] <= writeData;
    end
  end

  // Read port samples the array before this edge's write lands
  always_ff @(posedge clk) begin
    readData <= mem[readAddr];
  end

endmodule

`default_nettype wire

// ==== cacheWay.sv ====
/*
  One cache way. Holds the tag RAM, four word RAMs, and the valid and dirty
  bits. Compares the stored tag in stage 2 and forwards same-set writes over
  the RAM outputs, since the RAMs return old data on a colliding read
*/
`default_nettype none

`include "cache_defs.svh"

module cacheWay (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire cache_pkg::index_t    readIndex,
  input  wire cache_pkg::index_t    writeIndex,
  input  wire cache_pkg::tag_t      lookupTag,
  input  wire logic                 tagWrite,
  input  wire cache_pkg::tag_t      tagIn,
  input  wire cache_pkg::wordMask_t dataWrite,
  input  wire cache_pkg::line_t     dataIn,
  input  wire logic                 setValid,
  input  wire logic                 setDirty,
  input  wire logic                 clearDirty,
  input  wire logic                 invalidateAll,
  output cache_pkg::tag_t           wayTag,
  output cache_pkg::line_t          wayLine,
  output logic                      wayValid,
  output logic                      wayDirty,
  output logic                      wayHit
);

  cache_pkg::index_t    stage2Index;
  cache_pkg::tag_t      ramTag;
  cache_pkg::line_t     ramLine;
  logic [`NUM_SETS-1:0] validBits;
  logic [`NUM_SETS-1:0] dirtyBits;
  logic                 sameSet;
  logic                 fwdTagSel;
  cache_pkg::wordMask_t fwdWordSel;
  cache_pkg::tag_t      fwdTag;
  cache_pkg::line_t     fwdLine;

  ////////////////////////////////////////////////////////////////////////////
  // Tag and data RAMs
  ////////////////////////////////////////////////////////////////////////////

  // Tag is written only when a fill lands in this way
  sram2p #(.Width(`TAG_BITS), .Depth(`NUM_SETS)) tagRam (
    .clk         (clk),
    .readAddr    (readIndex),
    .readData    (ramTag),
    .writeAddr   (writeIndex),
    .writeEnable (tagWrite),
    .writeData   (tagIn)
  );

  // One RAM per word so a write hit touches a single word
  for (genvar w = 0; w < `LINE_WORDS; w++) begin : gWord
    sram2p #(.Width(`WORD_BITS), .Depth(`NUM_SETS)) dataRam (
      .clk         (clk),
      .readAddr    (readIndex),
      .readData    (ramLine[w*`WORD_BITS +: `WORD_BITS]),
      .writeAddr   (writeIndex),
      .writeEnable (dataWrite[w]),
      .writeData   (dataIn[w*`WORD_BITS +: `WORD_BITS])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Same-set write forwarding
  ////////////////////////////////////////////////////////////////////////////

  // The operation entering stage 2 reads the set that stage 2 writes now
  assign sameSet = (readIndex == writeIndex);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fwdTagSel  <= 1'b0;
      fwdWordSel <= '0;
    end else begin
      fwdTagSel  <= sameSet & tagWrite;
      fwdWordSel <= sameSet ? dataWrite : '0;
    end
  end

  // Stage 2 index and the values that may be forwarded
  always_ff @(posedge clk) begin
    stage2Index <= readIndex;
    fwdTag      <= tagIn;
    fwdLine     <= dataIn;
  end

  assign wayTag = fwdTagSel ? fwdTag : ramTag;

  // Forwarded words replace the stale RAM words one by one
  always_comb begin
    for (int w = 0; w < `LINE_WORDS; w++) begin
      wayLine[w*`WORD_BITS +: `WORD_BITS] = fwdWordSel[w] ?
          fwdLine[w*`WORD_BITS +: `WORD_BITS] : ramLine[w*`WORD_BITS +: `WORD_BITS];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and dirty bits
  ////////////////////////////////////////////////////////////////////////////

  // Invalidate wins over a set of the same edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;
    end else if (invalidateAll) begin
      validBits <= '0;
    end else if (setValid) begin
      validBits[writeIndex] <= 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dirtyBits <= '0;
    end else if (setDirty) begin
      dirtyBits[writeIndex] <= 1'b1;
    end else if (clearDirty) begin
      dirtyBits[writeIndex] <= 1'b0;
    end
  end

  // Flops are read directly, so a write of the previous edge is already seen
  assign wayValid = validBits[stage2Index];
  assign wayDirty = dirtyBits[stage2Index];
  assign wayHit   = wayValid & (wayTag == lookupTag);

endmodule

`default_nettype wire

// ==== cacheResolve.sv ====
/*
  Cache pipeline control. Registers each operation into stage 2, picks the
  hit or victim way, keeps the per-set LRU bits, drives the way write controls
  and registers the response and any dirty-line eviction
*/
`default_nettype none

`include "cache_defs.svh"

module cacheResolve (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 opValid,
  input  wire cache_pkg::cacheOp_t  op,
  input  wire cache_pkg::addr_t     addr,
  input  wire cache_pkg::word_t     wordIn,
  input  wire cache_pkg::line_t     lineIn,
  input  wire cache_pkg::tag_t      way0Tag,
  input  wire cache_pkg::line_t     way0Line,
  input  wire logic                 way0Valid,
  input  wire logic                 way0Dirty,
  input  wire logic                 way0Hit,
  input  wire cache_pkg::tag_t      way1Tag,
  input  wire cache_pkg::line_t     way1Line,
  input  wire logic                 way1Valid,
  input  wire logic                 way1Dirty,
  input  wire logic                 way1Hit,
  output cache_pkg::index_t         readIndex,
  output cache_pkg::index_t         writeIndex,
  output cache_pkg::tag_t           lookupTag,
  output cache_pkg::tag_t           tagIn,
  output cache_pkg::line_t          dataIn,
  output logic                      invalidateAll,
  output logic                      way0TagWrite,
  output cache_pkg::wordMask_t      way0DataWrite,
  output logic                      way0SetValid,
  output logic                      way0SetDirty,
  output logic                      way0ClearDirty,
  output logic                      way1TagWrite,
  output cache_pkg::wordMask_t      way1DataWrite,
  output logic                      way1SetValid,
  output logic                      way1SetDirty,
  output logic                      way1ClearDirty,
  output logic                      respValid,
  output logic                      respHit,
  output cache_pkg::word_t          respData,
  output logic                      evictValid,
  output cache_pkg::addr_t          evictAddr,
  output cache_pkg::line_t          evictLine
);

  logic                           s2Valid;
  cache_pkg::cacheOp_t            s2Op;
  cache_pkg::addr_t               s2Addr;
  cache_pkg::word_t               s2Word;
  cache_pkg::line_t               s2Line;
  cache_pkg::tag_t                s2Tag;
  cache_pkg::index_t              s2Index;
  logic [$clog2(`LINE_WORDS)-1:0] s2WordSel;
  logic                           isRead;
  logic                           isWrite;
  logic                           isFill;
  logic                           anyHit;
  logic                           hitWay;
  logic                           fillWay;
  logic                           victimValid;
  logic                           victimDirty;
  cache_pkg::tag_t                victimTag;
  cache_pkg::line_t               victimLine;
  cache_pkg::line_t               hitLine;
  cache_pkg::line_t               mergedLine;
  cache_pkg::word_t               hitWord;
  cache_pkg::wordMask_t           wordMask;
  logic [`NUM_SETS-1:0]           lruBits;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1 and the stage 2 registers
  ////////////////////////////////////////////////////////////////////////////

  // RAM read of both ways starts straight from the request
  assign readIndex = addr[`OFFSET_BITS +: `INDEX_BITS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s2Valid <= 1'b0;
    end else begin
      s2Valid <= opValid;
    end
  end

  // Operation payload only loads on a strobe
  always_ff @(posedge clk) begin
    if (opValid) begin
      s2Op   <= op;
      s2Addr <= addr;
      s2Word <= wordIn;
      s2Line <= lineIn;
    end
  end

  // Address fields, bits 1:0 are ignored
  assign s2Tag     = s2Addr[`ADDR_BITS-1 -: `TAG_BITS];
  assign s2Index   = s2Addr[`OFFSET_BITS +: `INDEX_BITS];
  assign s2WordSel = s2Addr[2 +: $clog2(`LINE_WORDS)];

  assign isRead        = s2Valid & (s2Op == cache_pkg::OpRead);
  assign isWrite       = s2Valid & (s2Op == cache_pkg::OpWrite);
  assign isFill        = s2Valid & (s2Op == cache_pkg::OpFill);
  assign invalidateAll = s2Valid & (s2Op == cache_pkg::OpInvalidate);

  ////////////////////////////////////////////////////////////////////////////
  // Hit and victim choice
  ////////////////////////////////////////////////////////////////////////////

  assign lookupTag = s2Tag;
  assign anyHit    = way0Hit | way1Hit;
  // A tag lives in at most one way, so way 1 hitting names the hit way
  assign hitWay    = way1Hit;
  assign hitLine   = hitWay ? way1Line : way0Line;
  assign hitWord   = hitLine[s2WordSel*`WORD_BITS +: `WORD_BITS];

  // Fill target order is hit way, free way 0, free way 1, then the LRU way
  always_comb begin
    if (anyHit) begin
      fillWay = hitWay;
    end else if (!way0Valid) begin
      fillWay = 1'b0;
    end else if (!way1Valid) begin
      fillWay = 1'b1;
    end else begin
      fillWay = lruBits[s2Index];
    end
  end

  assign victimValid = fillWay ? way1Valid : way0Valid;
  assign victimDirty = fillWay ? way1Dirty : way0Dirty;
  assign victimTag   = fillWay ? way1Tag : way0Tag;
  assign victimLine  = fillWay ? way1Line : way0Line;

  // LRU bit names the way to replace next, 0 after reset
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (isFill) begin
      lruBits[s2Index] <= ~fillWay;
    end else if ((isRead | isWrite) & anyHit) begin
      lruBits[s2Index] <= ~hitWay;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Way write controls
  ////////////////////////////////////////////////////////////////////////////

  assign wordMask = cache_pkg::wordMask_t'(1) << s2WordSel;

  // Write data is the hit line with the addressed word replaced
  always_comb begin
    mergedLine = hitLine;
    mergedLine[s2WordSel*`WORD_BITS +: `WORD_BITS] = s2Word;
  end

  assign writeIndex = s2Index;
  assign tagIn      = s2Tag;
  assign dataIn     = isFill ? s2Line : mergedLine;

  // A fill writes the whole line and tag, a write hit only its own word
  assign way0TagWrite   = isFill & ~fillWay;
  assign way0SetValid   = isFill & ~fillWay;
  assign way0ClearDirty = isFill & ~fillWay;
  assign way0SetDirty   = isWrite & way0Hit;
  assign way0DataWrite  = {`LINE_WORDS{way0TagWrite}} | ({`LINE_WORDS{way0SetDirty}} & wordMask);

  assign way1TagWrite   = isFill & fillWay;
  assign way1SetValid   = isFill & fillWay;
  assign way1ClearDirty = isFill & fillWay;
  assign way1SetDirty   = isWrite & way1Hit;
  assign way1DataWrite  = {`LINE_WORDS{way1TagWrite}} | ({`LINE_WORDS{way1SetDirty}} & wordMask);

  ////////////////////////////////////////////////////////////////////////////
  // Response and eviction registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      respValid  <= 1'b0;
      evictValid <= 1'b0;
    end else begin
      respValid  <= isRead | isWrite;
      evictValid <= isFill & victimValid & victimDirty;
    end
  end

  // Miss returns zero, write hit echoes the new word
  always_ff @(posedge clk) begin
    respHit   <= anyHit;
    respData  <= !anyHit ? '0 : (isWrite ? s2Word : hitWord);
    evictAddr <= {victimTag, s2Index, {`OFFSET_BITS{1'b0}}};
    evictLine <= victimLine;
  end

endmodule

`default_nettype wire

// ==== cacheTop.sv ====
/*
  Two-way set-associative write-back data cache core. Connects the pipeline
  control to its two ways
*/
`default_nettype none

module cacheTop (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                opValid,
  input  wire cache_pkg::cacheOp_t op,
  input  wire cache_pkg::addr_t    addr,
  input  wire cache_pkg::word_t    wordIn,
  input  wire cache_pkg::line_t    lineIn,
  output logic                     respValid,
  output logic                     respHit,
  output cache_pkg::word_t         respData,
  output logic                     evictValid,
  output cache_pkg::addr_t         evictAddr,
  output cache_pkg::line_t         evictLine
);

  // Shared controls from the resolve block to both ways
  cache_pkg::index_t    readIndex;
  cache_pkg::index_t    writeIndex;
  cache_pkg::tag_t      lookupTag;
  cache_pkg::tag_t      tagIn;
  cache_pkg::line_t     dataIn;
  logic                 invalidateAll;

  // Per-way write controls
  logic                 way0TagWrite;
  cache_pkg::wordMask_t way0DataWrite;
  logic                 way0SetValid;
  logic                 way0SetDirty;
  logic                 way0ClearDirty;
  logic                 way1TagWrite;
  cache_pkg::wordMask_t way1DataWrite;
  logic                 way1SetValid;
  logic                 way1SetDirty;
  logic                 way1ClearDirty;

  // Stage 2 state returned by each way
  cache_pkg::tag_t      way0Tag;
  cache_pkg::line_t     way0Line;
  logic                 way0Valid;
  logic                 way0Dirty;
  logic                 way0Hit;
  cache_pkg::tag_t      way1Tag;
  cache_pkg::line_t     way1Line;
  logic                 way1Valid;
  logic                 way1Dirty;
  logic                 way1Hit;

  cacheResolve resolve (.*);

  cacheWay way0 (
    .clk, .reset, .readIndex, .writeIndex, .lookupTag,
    .tagWrite (way0TagWrite), .tagIn, .dataWrite (way0DataWrite), .dataIn,
    .setValid (way0SetValid), .setDirty (way0SetDirty),
    .clearDirty (way0ClearDirty), .invalidateAll,
    .wayTag (way0Tag), .wayLine (way0Line), .wayValid (way0Valid),
    .wayDirty (way0Dirty), .wayHit (way0Hit)
  );

  cacheWay way1 (
    .clk, .reset, .readIndex, .writeIndex, .lookupTag,
    .tagWrite (way1TagWrite), .tagIn, .dataWrite (way1DataWrite), .dataIn,
    .setValid (way1SetValid), .setDirty (way1SetDirty),
    .clearDirty (way1ClearDirty), .invalidateAll,
    .wayTag (way1Tag), .wayLine (way1Line), .wayValid (way1Valid),
    .wayDirty (way1Dirty), .wayHit (way1Hit)
  );

endmodule

`default_nettype wire

// ==== cache_properties.sv ====
/*
  Port timing checks for the cache. Each response or eviction strobe must
  trace back to a matching request two cycles earlier
*/
`default_nettype none

module cacheProperties (
  input wire logic                clk,
  input wire logic                reset,
  input wire logic                opValid,
  input wire cache_pkg::cacheOp_t op,
  input wire logic                respValid,
  input wire logic                evictValid
);
  timeunit 1ns;
  timeprecision 1ps;

  // A response belongs to a read or write issued two cycles before
  respFromAccess: assert property (@(posedge clk) disable iff (reset)
    respValid |-> $past(opValid, 2) &&
      ($past(op, 2) == cache_pkg::OpRead || $past(op, 2) == cache_pkg::OpWrite))
    else $error("respValid without a read or write two cycles earlier");

  // Only a fill can push a line out
  evictFromFill: assert property (@(posedge clk) disable iff (reset)
    evictValid |-> $past(opValid, 2) && $past(op, 2) == cache_pkg::OpFill)
    else $error("evictValid without a fill two cycles earlier");

  // Both strobes stay quiet while reset is held
  quietInReset: assert property (@(posedge clk) reset |-> !respValid && !evictValid)
    else $error("a strobe is high during reset");

endmodule

bind cacheTop cacheProperties props (.*);

`default_nettype wire

// ==== cache_tb.sv ====
/*
  Testbench for the two-way data cache. Issues reads, writes, fills and
  invalidates, predicts each response and eviction with a reference model,
  and checks them two cycles after issue
*/
`default_nettype none

`include "cache_defs.svh"

module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClockPeriod = 40;
  localparam int DrainCycles = 3;
  localparam int NumTests    = 6;
  // Operations issued over all six tests
  localparam int PlannedOps  = 442;
  // Drain cycles count as issued slots in the time budget
  localparam int WatchdogNs  = (PlannedOps + NumTests * DrainCycles + 20) * ClockPeriod;

  // One predicted result, checked on the cycle given by due
  typedef struct packed {
    int               due;
    logic             respValid;
    logic             respHit;
    cache_pkg::word_t respData;
    logic             evictValid;
    cache_pkg::addr_t evictAddr;
    cache_pkg::line_t evictLine;
  } expect_t;

  logic                clk;
  logic                reset;
  logic                opValid;
  cache_pkg::cacheOp_t op;
  cache_pkg::addr_t    addr;
  cache_pkg::word_t    wordIn;
  cache_pkg::line_t    lineIn;
  logic                respValid;
  logic                respHit;
  cache_pkg::word_t    respData;
  logic                evictValid;
  cache_pkg::addr_t    evictAddr;
  cache_pkg::line_t    evictLine;

  // Reference state, one entry per way and set
  cache_pkg::tag_t  modelTag   [2][`NUM_SETS];
  cache_pkg::line_t modelLine  [2][`NUM_SETS];
  logic             modelValid [2][`NUM_SETS];
  logic             modelDirty [2][`NUM_SETS];
  logic             modelLru   [`NUM_SETS];

  expect_t expQ[$];
  int      seed = 32'ha615;
  int      cycleCount = 0;
  int      errorCount = 0;
  int      checkCount = 0;
  int      testCount = 0;
  int      testFailed = 0;
  int      errorsAtStart = 0;
  string   testName;

  cacheTop i_cacheTop (
    .clk, .reset, .opValid, .op, .addr, .wordIn, .lineIn,
    .respValid, .respHit, .respData, .evictValid, .evictAddr, .evictLine
  );

  always #(ClockPeriod / 2) clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Applies one operation to the model in issue order and returns its result
  function automatic expect_t refOp(input cache_pkg::cacheOp_t o, input cache_pkg::addr_t a,
                                    input cache_pkg::word_t w, input cache_pkg::line_t l);
    expect_t           e;
    cache_pkg::tag_t   t;
    cache_pkg::index_t s;
    int                pos;
    logic              anyHit;
    int                way;
    e      = '0;
    t      = a[`ADDR_BITS-1 -: `TAG_BITS];
    s      = a[`OFFSET_BITS +: `INDEX_BITS];
    pos    = int'(a[3:2]) * `WORD_BITS;
    way    = (modelValid[1][s] && modelTag[1][s] == t) ? 1 : 0;
    anyHit = modelValid[way][s] && modelTag[way][s] == t;
    case (o)
      cache_pkg::OpRead, cache_pkg::OpWrite: begin
        e.respValid = 1'b1;
        if (anyHit) begin
          e.respHit = 1'b1;
          if (o == cache_pkg::OpWrite) begin
            modelLine[way][s][pos +: `WORD_BITS] = w;
            modelDirty[way][s] = 1'b1;
          end
          e.respData = modelLine[way][s][pos +: `WORD_BITS];
          // The way just used becomes most recent
          modelLru[s] = (way == 0);
        end
      end
      cache_pkg::OpFill: begin
        if (!anyHit) begin
          if (!modelValid[0][s]) begin
            way = 0;
          end else if (!modelValid[1][s]) begin
            way = 1;
          end else begin
            way = int'(modelLru[s]);
          end
        end
        // Only a valid dirty target goes back out
        if (modelValid[way][s] && modelDirty[way][s]) begin
          e.evictValid = 1'b1;
          e.evictAddr  = {modelTag[way][s], s, {`OFFSET_BITS{1'b0}}};
          e.evictLine  = modelLine[way][s];
        end
        modelTag[way][s]   = t;
        modelLine[way][s]  = l;
        modelValid[way][s] = 1'b1;
        modelDirty[way][s] = 1'b0;
        modelLru[s]        = (way == 0);
      end
      default: begin
        for (int i = 0; i < `NUM_SETS; i++) begin
          modelValid[0][i] = 1'b0;
          modelValid[1][i] = 1'b0;
        end
      end
    endcase
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and the compare process
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkResp(input cache_pkg::word_t expData, input logic expHit);
    checkCount++;
    if (respHit !== expHit) begin
      errorCount++;
      $display("error respHit: got %h expected %h at cycle %0d", respHit, expHit, cycleCount);
    end
    if (respData !== expData) begin
      errorCount++;
      $display("error respData: got %h expected %h at cycle %0d", respData, expData, cycleCount);
    end
  endtask

  task automatic checkEvict(input cache_pkg::addr_t expAddr, input cache_pkg::line_t expLine);
    checkCount++;
    if (evictAddr !== expAddr) begin
      errorCount++;
      $display("error evictAddr: got %h expected %h at cycle %0d", evictAddr, expAddr,
               cycleCount);
    end
    if (evictLine !== expLine) begin
      errorCount++;
      $display("error evictLine: got %h expected %h at cycle %0d", evictLine, expLine,
               cycleCount);
    end
  endtask

  // Outputs are settled at the falling edge, halfway through the cycle
  always @(negedge clk) begin : compareResults
    expect_t e;
    logic    expResp;
    logic    expEvict;
    e        = '0;
    expResp  = 1'b0;
    expEvict = 1'b0;
    if (!reset) begin
      if (expQ.size() > 0 && expQ[0].due == cycleCount) begin
        e        = expQ.pop_front();
        expResp  = e.respValid;
        expEvict = e.evictValid;
      end
      if (respValid !== expResp) begin
        errorCount++;
        $display("response strobe was %s at cycle %0d", expResp ? "missing" : "unexpected",
                 cycleCount);
      end else if (expResp) begin
        checkResp(e.respData, e.respHit);
      end
      if (evictValid !== expEvict) begin
        errorCount++;
        $display("eviction strobe was %s at cycle %0d", expEvict ? "missing" : "unexpected",
                 cycleCount);
      end else if (expEvict) begin
        checkEvict(e.evictAddr, e.evictLine);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Drives one strobe and queues its prediction for two cycles later
  task automatic issue(input cache_pkg::cacheOp_t o, input cache_pkg::addr_t a,
                       input cache_pkg::word_t w, input cache_pkg::line_t l);
    expect_t e;
    opValid = 1'b1;
    op      = o;
    addr    = a;
    wordIn  = w;
    lineIn  = l;
    e       = refOp(o, a, w, l);
    e.due   = cycleCount + 2;
    if (e.respValid || e.evictValid) begin
      expQ.push_back(e);
    end
    @(posedge clk);
    #2;
    opValid = 1'b0;
  endtask

  task automatic idle(input int n);
    opValid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic randomLine(output cache_pkg::line_t l);
    for (int k = 0; k < `LINE_WORDS; k++) begin
      l[k*`WORD_BITS +: `WORD_BITS] = $random(seed);
    end
  endtask

  // Three tags compete for each set in the random mix
  function automatic cache_pkg::tag_t pickTag(input logic [1:0] sel);
    case (sel)
      2'd0:    return 8'h11;
      2'd1:    return 8'h5a;
      default: return 8'hc3;
    endcase
  endfunction

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  // Lets the pipeline empty and prints the result of the test
  task automatic finishTest();
    idle(DrainCycles);
    testCount++;
    if (expQ.size() != 0) begin
      errorCount++;
      $display("%0d predicted results were never seen", expQ.size());
      expQ.delete();
    end
    if (errorCount == errorsAtStart) begin
      $display("test %0d %s: ok", testCount, testName);
    end else begin
      testFailed++;
      $display("test %0d %s: %0d errors", testCount, testName, errorCount - errorsAtStart);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : mainSequence
    logic [31:0]         r;
    cache_pkg::word_t    w;
    cache_pkg::line_t    l;
    cache_pkg::addr_t    savedAddr [4];
    cache_pkg::cacheOp_t o;
    clk     = 1'b0;
    reset   = 1'b1;
    opValid = 1'b0;
    op      = cache_pkg::OpRead;
    addr    = '0;
    wordIn  = '0;
    lineIn  = '0;
    for (int i = 0; i < `NUM_SETS; i++) begin
      modelValid[0][i] = 1'b0;
      modelValid[1][i] = 1'b0;
      modelDirty[0][i] = 1'b0;
      modelDirty[1][i] = 1'b0;
      modelLru[i]      = 1'b0;
    end
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    // Nothing is valid yet, so every access misses
    startTest("cold miss");
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      issue(cache_pkg::OpRead, r[15:0], '0, '0);
    end
    for (int k = 0; k < 4; k++) begin
      r = $random(seed);
      savedAddr[k] = r[15:0];
      w = $random(seed);
      issue(cache_pkg::OpWrite, savedAddr[k], w, '0);
    end
    for (int k = 0; k < 4; k++) begin
      issue(cache_pkg::OpRead, savedAddr[k], '0, '0);
    end
    finishTest();

    startTest("fill then hit");
    randomLine(l);
    issue(cache_pkg::OpFill, 16'h1230, '0, l);
    for (int k = 0; k < `LINE_WORDS; k++) begin
      issue(cache_pkg::OpRead, {8'h12, 4'h3, k[1:0], 2'b00}, '0, '0);
    end
    finishTest();

    // Back-to-back accesses to set 3 lean on the forwarding path
    startTest("write hit and bypass");
    w = $random(seed);
    issue(cache_pkg::OpWrite, 16'h1234, w, '0);
    issue(cache_pkg::OpRead, 16'h1234, '0, '0);
    w = $random(seed);
    issue(cache_pkg::OpWrite, 16'h1238, w, '0);
    randomLine(l);
    issue(cache_pkg::OpFill, 16'h4530, '0, l);
    issue(cache_pkg::OpRead, 16'h1238, '0, '0);
    issue(cache_pkg::OpRead, 16'h4534, '0, '0);
    finishTest();

    // The third fill pushes out the dirty first line of set 5
    startTest("replacement and eviction");
    randomLine(l);
    issue(cache_pkg::OpFill, 16'h1050, '0, l);
    w = $random(seed);
    issue(cache_pkg::OpWrite, 16'h1050, w, '0);
    randomLine(l);
    issue(cache_pkg::OpFill, 16'h2050, '0, l);
    randomLine(l);
    issue(cache_pkg::OpFill, 16'h3050, '0, l);
    randomLine(l);
    issue(cache_pkg::OpFill, 16'h4050, '0, l);
    issue(cache_pkg::OpRead, 16'h3054, '0, '0);
    issue(cache_pkg::OpRead, 16'h4058, '0, '0);
    finishTest();

    // A stale dirty bit must not cause an eviction after the invalidate
    startTest("invalidate all");
    issue(cache_pkg::OpInvalidate, '0, '0, '0);
    issue(cache_pkg::OpRead, 16'h1230, '0, '0);
    issue(cache_pkg::OpRead, 16'h4534, '0, '0);
    issue(cache_pkg::OpRead, 16'h3054, '0, '0);
    issue(cache_pkg::OpRead, 16'h4058, '0, '0);
    randomLine(l);
    issue(cache_pkg::OpFill, 16'h3050, '0, l);
    randomLine(l);
    issue(cache_pkg::OpFill, 16'h1230, '0, l);
    issue(cache_pkg::OpRead, 16'h123c, '0, '0);
    finishTest();

    // Four sets and three tags keep hits and evictions frequent
    startTest("random mix");
    for (int k = 0; k < 400; k++) begin
      r = $random(seed);
      if (r[9:4] == 6'd0) begin
        o = cache_pkg::OpInvalidate;
      end else if (r[3:0] < 4'd4) begin
        o = cache_pkg::OpFill;
      end else if (r[3:0] < 4'd10) begin
        o = cache_pkg::OpRead;
      end else begin
        o = cache_pkg::OpWrite;
      end
      w = $random(seed);
      randomLine(l);
      issue(o, {pickTag(r[11:10]), 2'b00, r[13:12], r[15:14], r[17:16]}, w, l);
    end
    finishTest();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", testCount, testFailed,
             checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("timeout: the run did not finish within %0d ns", WatchdogNs);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
cache_pkg.sv
sram2p.sv
cacheWay.sv
cacheResolve.sv
cacheTop.sv
cache_properties.sv
cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module cache_tb -o cache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
